//--- Bender.yml
package:
  name: ee_exec

sources:
  - src/ee_pkg.sv
  - src/muldiv_if.sv
  - src/ee_alu.sv
  - src/ee_mul.sv
  - src/ee_div.sv
  - src/ee_muldiv_ctrl.sv
  - src/ee_hilo.sv
  - src/ee_exec_top.sv
  - target: test
    files:
      - verif/ee_exec_asserts.sv
      - verif/tb_ee_exec.sv

//--- flist.f
src/ee_pkg.sv
src/muldiv_if.sv
src/ee_alu.sv
src/ee_mul.sv
src/ee_div.sv
src/ee_muldiv_ctrl.sv
src/ee_hilo.sv
src/ee_exec_top.sv
verif/ee_exec_asserts.sv
verif/tb_ee_exec.sv

//--- src/ee_alu.sv
`timescale 1ns/1ns
`default_nettype none

module ee_alu import ee_pkg::*; (
    input  word_t   src_a_i,
    input  word_t   src_b_i,
    input  alu_op_e op_i,
    input  dword_t  hilo_i,
    output word_t   result_o,
    output logic    overflow_o
);

    word_t sum;
    word_t diff;
    logic  add_ovf;
    logic  sub_ovf;

    assign sum  = src_a_i + src_b_i;
    assign diff = src_a_i - src_b_i;

    // Operands agree in sign but the sum does not
    assign add_ovf = (src_a_i[XLEN-1] == src_b_i[XLEN-1]) &
                     (sum[XLEN-1] != src_a_i[XLEN-1]);
    assign sub_ovf = (src_a_i[XLEN-1] != src_b_i[XLEN-1]) &
                     (diff[XLEN-1] != src_a_i[XLEN-1]);

    always_comb begin
        result_o   = '0;
        overflow_o = 1'b0;
        case (op_i)
            OP_ADD: begin
                result_o   = sum;
                overflow_o = add_ovf;
            end
            OP_ADDU: begin
                result_o = sum;
            end
            OP_SUB: begin
                result_o   = diff;
                overflow_o = sub_ovf;
            end
            OP_SUBU: begin
                result_o = diff;
            end
            OP_AND: begin
                result_o = src_a_i & src_b_i;
            end
            OP_OR: begin
                result_o = src_a_i | src_b_i;
            end
            OP_XOR: begin
                result_o = src_a_i ^ src_b_i;
            end
            OP_NOR: begin
                result_o = ~(src_a_i | src_b_i);
            end
            OP_SLT: begin
                result_o = word_t'($signed(src_a_i) < $signed(src_b_i));
            end
            OP_SLTU: begin
                result_o = word_t'(src_a_i < src_b_i);
            end
            OP_MFHI: begin
                result_o = hilo_i[2*XLEN-1:XLEN];
            end
            OP_MFLO: begin
                result_o = hilo_i[XLEN-1:0];
            end
            default: begin
                result_o = '0; // Multi-cycle ops and moves into HI/LO
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/ee_div.sv
`timescale 1ns/1ns
`default_nettype none

module ee_div import ee_pkg::*; (
    input  logic   clk_i,
    input  logic   arst_n_i,
    muldiv_if.unit bus
);

    localparam int CNT_W = $clog2(DIV_STEPS);

    typedef enum logic [1:0] {DIV_IDLE, DIV_BUSY, DIV_DONE} div_state_e;

    div_state_e       state_q;
    logic [CNT_W-1:0] cnt_q;
    logic             launch;
    word_t            a_mag;
    word_t            b_mag;
    logic [XLEN:0]    shifted;
    logic [XLEN:0]    trial;
    logic             fits;
    word_t            rem_q;
    word_t            quo_q;
    word_t            dvs_q;
    logic             q_neg_q;
    logic             r_neg_q;
    word_t            quo_out;
    word_t            rem_out;

    assign launch = (state_q == DIV_IDLE) & bus.start & ~bus.flush;
    assign a_mag  = (bus.is_signed & bus.op_a[XLEN-1]) ? -bus.op_a : bus.op_a;
    assign b_mag  = (bus.is_signed & bus.op_b[XLEN-1]) ? -bus.op_b : bus.op_b;

    // Next dividend bit enters the partial remainder, then one trial subtract
    assign shifted = {rem_q, quo_q[XLEN-1]};
    assign trial   = shifted - {1'b0, dvs_q};
    assign fits    = shifted >= {1'b0, dvs_q};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= DIV_IDLE;
            cnt_q   <= '0;
        end else if (bus.flush) begin
            state_q <= DIV_IDLE;
        end else begin
            case (state_q)
                DIV_IDLE: begin
                    if (launch) begin
                        state_q <= DIV_BUSY; // Setup cycle
                        cnt_q   <= '0;
                    end
                end
                DIV_BUSY: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CNT_W'(DIV_STEPS - 1)) begin
                        state_q <= DIV_DONE;
                    end
                end
                default: begin
                    state_q <= DIV_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (launch) begin
            dvs_q   <= b_mag;
            quo_q   <= a_mag; // Dividend shifts out as quotient shifts in
            rem_q   <= '0;
            q_neg_q <= bus.is_signed & (bus.op_a[XLEN-1] ^ bus.op_b[XLEN-1]);
            r_neg_q <= bus.is_signed & bus.op_a[XLEN-1];
        end else if (state_q == DIV_BUSY) begin
            rem_q <= fits ? trial[XLEN-1:0] : shifted[XLEN-1:0];
            quo_q <= {quo_q[XLEN-2:0], fits};
        end
    end

    // A zero divisor leaves all ones in the quotient, kept as is
    assign quo_out = (q_neg_q && dvs_q != '0) ? -quo_q : quo_q;
    assign rem_out = r_neg_q ? -rem_q : rem_q; // Remainder takes the dividend sign

    assign bus.ready  = (state_q == DIV_DONE) & ~bus.flush;
    assign bus.result = {rem_out, quo_out};

endmodule

`default_nettype wire

//--- src/ee_exec_top.sv
`timescale 1ns/1ns
`default_nettype none

module ee_exec_top import ee_pkg::*; #(
    parameter int MUL_BITS_PER_CYCLE = 4
) (
    input  logic    clk_i,
    input  logic    arst_n_i,
    input  logic    flush_master_i,
    input  logic    flush_slave_i,
    input  logic    flush_ex_i,
    input  word_t   src1_a_i,
    input  word_t   src1_b_i,
    input  word_t   src2_a_i,
    input  word_t   src2_b_i,
    input  alu_op_e op1_i,
    input  alu_op_e op2_i,
    output logic    stall_o,
    output word_t   result1_o,
    output word_t   result2_o,
    output logic    overflow1_o,
    output logic    overflow2_o
);

    dword_t hilo;
    dword_t hilo_wdata;
    logic   hi_we;
    logic   lo_we;

    muldiv_if mul_bus ();
    muldiv_if div_bus ();

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    ee_alu i_alu_master (
        .src_a_i    (src1_a_i),
        .src_b_i    (src1_b_i),
        .op_i       (op1_i),
        .hilo_i     (hilo),
        .result_o   (result1_o),
        .overflow_o (overflow1_o)
    );

    ee_alu i_alu_slave (
        .src_a_i    (src2_a_i),
        .src_b_i    (src2_b_i),
        .op_i       (op2_i),
        .hilo_i     (hilo),
        .result_o   (result2_o),
        .overflow_o (overflow2_o)
    );

    ee_muldiv_ctrl i_muldiv_ctrl (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .src1_a_i       (src1_a_i),
        .src1_b_i       (src1_b_i),
        .src2_a_i       (src2_a_i),
        .src2_b_i       (src2_b_i),
        .op1_i          (op1_i),
        .op2_i          (op2_i),
        .flush_master_i (flush_master_i),
        .flush_slave_i  (flush_slave_i),
        .flush_ex_i     (flush_ex_i),
        .hilo_i         (hilo),
        .mul            (mul_bus.ctrl),
        .div            (div_bus.ctrl),
        .hi_we_o        (hi_we),
        .lo_we_o        (lo_we),
        .hilo_wdata_o   (hilo_wdata),
        .stall_o        (stall_o)
    );

    ee_mul #(
        .MUL_BITS_PER_CYCLE (MUL_BITS_PER_CYCLE)
    ) i_mul (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .bus      (mul_bus.unit)
    );

    ee_div i_div (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .bus      (div_bus.unit)
    );

    ee_hilo i_hilo (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .hi_we_i  (hi_we),
        .lo_we_i  (lo_we),
        .wdata_i  (hilo_wdata),
        .hilo_o   (hilo)
    );

endmodule

`default_nettype wire

//--- src/ee_hilo.sv
`timescale 1ns/1ns
`default_nettype none

module ee_hilo import ee_pkg::*; (
    input  logic   clk_i,
    input  logic   arst_n_i,
    input  logic   hi_we_i,
    input  logic   lo_we_i,
    input  dword_t wdata_i,
    output dword_t hilo_o
);

    word_t hi_q;
    word_t lo_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else begin
            if (hi_we_i) begin
                hi_q <= wdata_i[2*XLEN-1:XLEN];
            end
            if (lo_we_i) begin
                lo_q <= wdata_i[XLEN-1:0];
            end
        end
    end

    assign hilo_o = {hi_q, lo_q};

endmodule

`default_nettype wire

//--- src/ee_mul.sv
`timescale 1ns/1ns
`default_nettype none

module ee_mul import ee_pkg::*; #(
    parameter int MUL_BITS_PER_CYCLE = 4
) (
    input  logic   clk_i,
    input  logic   arst_n_i,
    muldiv_if.unit bus
);

    localparam int STEPS = XLEN / MUL_BITS_PER_CYCLE;
    localparam int CNT_W = $clog2(STEPS);

    typedef enum logic [1:0] {MUL_IDLE, MUL_BUSY, MUL_DONE} mul_state_e;

    mul_state_e                    state_q;
    logic [CNT_W-1:0]              cnt_q;
    logic                          launch;
    word_t                         a_mag;
    word_t                         b_mag;
    dword_t                        pp_mcand;
    logic [MUL_BITS_PER_CYCLE-1:0] pp_digit;
    dword_t                        pp;
    dword_t                        mcand_q;
    word_t                         mplier_q;
    dword_t                        acc_q;
    logic                          neg_q;

    assign launch = (state_q == MUL_IDLE) & bus.start & ~bus.flush;
    assign a_mag  = (bus.is_signed & bus.op_a[XLEN-1]) ? -bus.op_a : bus.op_a;
    assign b_mag  = (bus.is_signed & bus.op_b[XLEN-1]) ? -bus.op_b : bus.op_b;

    // The first digit is taken straight from the bus in the start cycle
    assign pp_mcand = (state_q == MUL_IDLE) ? dword_t'(a_mag) : mcand_q;
    assign pp_digit = (state_q == MUL_IDLE) ? b_mag[MUL_BITS_PER_CYCLE-1:0] :
                                              mplier_q[MUL_BITS_PER_CYCLE-1:0];
    assign pp       = pp_mcand * dword_t'(pp_digit);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= MUL_IDLE;
            cnt_q   <= '0;
        end else if (bus.flush) begin
            state_q <= MUL_IDLE;
        end else begin
            case (state_q)
                MUL_IDLE: begin
                    if (launch) begin
                        state_q <= MUL_BUSY;
                        cnt_q   <= CNT_W'(1);
                    end
                end
                MUL_BUSY: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CNT_W'(STEPS - 1)) begin
                        state_q <= MUL_DONE;
                    end
                end
                default: begin
                    state_q <= MUL_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (launch) begin
            mcand_q  <= dword_t'(a_mag) << MUL_BITS_PER_CYCLE;
            mplier_q <= b_mag >> MUL_BITS_PER_CYCLE;
            acc_q    <= pp;
            neg_q    <= bus.is_signed & (bus.op_a[XLEN-1] ^ bus.op_b[XLEN-1]);
        end else if (state_q == MUL_BUSY) begin
            mcand_q  <= mcand_q << MUL_BITS_PER_CYCLE;
            mplier_q <= mplier_q >> MUL_BITS_PER_CYCLE;
            acc_q    <= acc_q + pp;
        end
    end

    assign bus.ready  = (state_q == MUL_DONE) & ~bus.flush;
    assign bus.result = neg_q ? -acc_q : acc_q; // Sign restored on the way out

endmodule

`default_nettype wire

//--- src/ee_muldiv_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module ee_muldiv_ctrl import ee_pkg::*; (
    input  logic    clk_i,
    input  logic    arst_n_i,
    input  word_t   src1_a_i,
    input  word_t   src1_b_i,
    input  word_t   src2_a_i,
    input  word_t   src2_b_i,
    input  alu_op_e op1_i,
    input  alu_op_e op2_i,
    input  logic    flush_master_i,
    input  logic    flush_slave_i,
    input  logic    flush_ex_i,
    input  dword_t  hilo_i,
    muldiv_if.ctrl  mul,
    muldiv_if.ctrl  div,
    output logic    hi_we_o,
    output logic    lo_we_o,
    output dword_t  hilo_wdata_o,
    output logic    stall_o
);

    logic    master_md;
    logic    slave_md;
    logic    has_op;
    alu_op_e sel_op;
    word_t   sel_a;
    word_t   sel_b;
    logic    sel_flush;
    logic    sel_mul;
    logic    sel_div;
    logic    done;
    logic    flushed_q;
    dword_t  md_wdata;
    word_t   hi_wdata;
    word_t   lo_wdata;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign master_md = is_mul_op(op1_i) | is_div_op(op1_i);
    assign slave_md  = is_mul_op(op2_i) | is_div_op(op2_i);
    assign has_op    = master_md | slave_md;

    assign sel_op    = master_md ? op1_i : op2_i; // Master first, slave only if master has none
    assign sel_a     = master_md ? src1_a_i : src2_a_i;
    assign sel_b     = master_md ? src1_b_i : src2_b_i;
    assign sel_flush = master_md ? flush_master_i : flush_slave_i;
    assign sel_mul   = is_mul_op(sel_op);
    assign sel_div   = is_div_op(sel_op);

    assign mul.op_a      = sel_a;
    assign mul.op_b      = sel_b;
    assign mul.is_signed = sel_op inside {OP_MULT, OP_MADD, OP_MSUB};
    assign mul.flush     = sel_flush;
    assign mul.start     = sel_mul & ~mul.ready & ~flushed_q;

    assign div.op_a      = sel_a;
    assign div.op_b      = sel_b;
    assign div.is_signed = (sel_op == OP_DIV);
    assign div.flush     = sel_flush;
    assign div.start     = sel_div & ~div.ready & ~flushed_q;

    assign done    = (sel_mul & mul.ready) | (sel_div & div.ready);
    assign stall_o = has_op & ~done & ~flushed_q;

    // A flushed op stays parked for the cycle in which the lane moves on
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            flushed_q <= 1'b0;
        end else begin
            flushed_q <= has_op & sel_flush & ~flushed_q;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (sel_op)
            OP_MADD, OP_MADDU: md_wdata = hilo_i + mul.result;
            OP_MSUB, OP_MSUBU: md_wdata = hilo_i - mul.result;
            OP_DIV, OP_DIVU:   md_wdata = div.result;
            default:           md_wdata = mul.result;
        endcase
    end

    // Completing unit owns both halves, otherwise MTHI and MTLO with master priority
    assign hi_wdata = done ? md_wdata[2*XLEN-1:XLEN] :
                      (op1_i == OP_MTHI) ? src1_a_i : src2_a_i;
    assign lo_wdata = done ? md_wdata[XLEN-1:0] :
                      (op1_i == OP_MTLO) ? src1_a_i : src2_a_i;

    assign hi_we_o = (done | op1_i == OP_MTHI | op2_i == OP_MTHI) & ~flush_ex_i;
    assign lo_we_o = (done | op1_i == OP_MTLO | op2_i == OP_MTLO) & ~flush_ex_i;
    assign hilo_wdata_o = {hi_wdata, lo_wdata};

endmodule

`default_nettype wire

//--- src/ee_pkg.sv
`default_nettype none

package ee_pkg;

    localparam int XLEN      = 32;
    localparam int DIV_STEPS = XLEN; // One quotient bit per step

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [2*XLEN-1:0] dword_t; // HI in the upper half

    typedef enum logic [7:0] {
        OP_NOP   = 8'h00,
        OP_ADD   = 8'h01,
        OP_ADDU  = 8'h02,
        OP_SUB   = 8'h03,
        OP_SUBU  = 8'h04,
        OP_AND   = 8'h05,
        OP_OR    = 8'h06,
        OP_XOR   = 8'h07,
        OP_NOR   = 8'h08,
        OP_SLT   = 8'h09,
        OP_SLTU  = 8'h0a,
        OP_MFHI  = 8'h10,
        OP_MFLO  = 8'h11,
        OP_MTHI  = 8'h12,
        OP_MTLO  = 8'h13,
        OP_MULT  = 8'h20,
        OP_MULTU = 8'h21,
        OP_MADD  = 8'h22,
        OP_MADDU = 8'h23,
        OP_MSUB  = 8'h24,
        OP_MSUBU = 8'h25,
        OP_DIV   = 8'h28,
        OP_DIVU  = 8'h29
    } alu_op_e;

    // Everything that goes through the shared multiplier
    function automatic logic is_mul_op(input alu_op_e op);
        return op inside {OP_MULT, OP_MULTU, OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};
    endfunction

    function automatic logic is_div_op(input alu_op_e op);
        return op inside {OP_DIV, OP_DIVU};
    endfunction

endpackage

`default_nettype wire

//--- src/muldiv_if.sv
`timescale 1ns/1ns
`default_nettype none

interface muldiv_if import ee_pkg::*; ();

    word_t  op_a;
    word_t  op_b;
    logic   is_signed;
    logic   start;      // Level, held until ready
    logic   flush;
    logic   ready;      // One cycle pulse
    dword_t result;     // Product, or remainder in HI and quotient in LO

    modport ctrl (
        output op_a, op_b, is_signed, start, flush,
        input  ready, result
    );

    modport unit (
        input  op_a, op_b, is_signed, start, flush,
        output ready, result
    );

endinterface

`default_nettype wire

//--- verif/ee_exec_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module ee_exec_asserts import ee_pkg::*; (
    input  logic    clk_i,
    input  logic    arst_n_i,
    input  alu_op_e op1_i,
    input  alu_op_e op2_i,
    input  logic    mul_start_i,
    input  logic    mul_ready_i,
    input  logic    div_start_i,
    input  logic    div_ready_i,
    input  logic    stall_i
);

    logic any_md;
    int   fail_count = 0;

    assign any_md = is_mul_op(op1_i) | is_div_op(op1_i) | is_mul_op(op2_i) | is_div_op(op2_i);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_ready_exclusive: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) !(mul_ready_i && div_ready_i)
    ) else begin
        $error("Both units signal ready in the same cycle");
        fail_count++;
    end

    // Start was held up to the ready cycle and drops with it
    a_mul_start_drop: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) mul_ready_i |-> $fell(mul_start_i)
    ) else begin
        $error("Multiplier start did not fall in the ready cycle");
        fail_count++;
    end

    a_div_start_drop: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) div_ready_i |-> $fell(div_start_i)
    ) else begin
        $error("Divider start did not fall in the ready cycle");
        fail_count++;
    end

    a_stall_needs_op: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) !any_md |-> !stall_i
    ) else begin
        $error("Stall raised without a multi-cycle operation in either lane");
        fail_count++;
    end

endmodule

`default_nettype wire

//--- verif/tb_ee_exec.sv
`timescale 1ns/1ns
`default_nettype none

module tb_ee_exec;
    import ee_pkg::*;

    localparam int CLK_HALF     = 20;
    localparam int SETTLE       = 10; // Quarter period after the falling edge
    localparam int RESET_CYCLES = 10;
    localparam int MUL_BITS     = 4;
    localparam int N_ALU        = 200;
    localparam int N_MOVE       = 60;
    localparam int N_MD         = 40;
    localparam int N_MAC        = 24;
    localparam int N_DUAL       = 8;
    localparam int N_FLUSH      = 8;
    localparam int TOTAL_OPS    = N_ALU + N_MOVE + 2 * (N_MD + N_MAC + N_DUAL + N_FLUSH) + 8;
    localparam int LIMIT_CYCLES = TOTAL_OPS * 40 + RESET_CYCLES + 100;

    logic    clk_i = 1'b0;
    logic    arst_n_i;
    logic    flush_master;
    logic    flush_slave;
    logic    flush_ex;
    word_t   src1_a;
    word_t   src1_b;
    word_t   src2_a;
    word_t   src2_b;
    alu_op_e op1;
    alu_op_e op2;
    logic    stall_o;
    word_t   result1_o;
    word_t   result2_o;
    logic    overflow1_o;
    logic    overflow2_o;

    dword_t  model_hilo;
    int      checks = 0;
    int      errors = 0;
    int      test_checks = 0;
    int      test_errors = 0;
    int      cycle_count = 0;

    alu_op_e single_ops[13] = '{OP_NOP, OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_AND, OP_OR,
                                OP_XOR, OP_NOR, OP_SLT, OP_SLTU, OP_MFHI, OP_MFLO};
    alu_op_e move_ops[5]    = '{OP_MTHI, OP_MTLO, OP_MFHI, OP_MFLO, OP_NOP};
    alu_op_e md_ops[4]      = '{OP_MULT, OP_MULTU, OP_DIV, OP_DIVU};
    alu_op_e mac_ops[4]     = '{OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};

    ee_exec_top #(
        .MUL_BITS_PER_CYCLE (MUL_BITS)
    ) i_ee_exec_top (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .flush_master_i (flush_master),
        .flush_slave_i  (flush_slave),
        .flush_ex_i     (flush_ex),
        .src1_a_i       (src1_a),
        .src1_b_i       (src1_b),
        .src2_a_i       (src2_a),
        .src2_b_i       (src2_b),
        .op1_i          (op1),
        .op2_i          (op2),
        .stall_o        (stall_o),
        .result1_o      (result1_o),
        .result2_o      (result2_o),
        .overflow1_o    (overflow1_o),
        .overflow2_o    (overflow2_o)
    );

    bind ee_muldiv_ctrl ee_exec_asserts i_ctrl_asserts (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .op1_i       (op1_i),
        .op2_i       (op2_i),
        .mul_start_i (mul.start),
        .mul_ready_i (mul.ready),
        .div_start_i (div.start),
        .div_ready_i (div.ready),
        .stall_i     (stall_o)
    );

    always #CLK_HALF clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= LIMIT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", LIMIT_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s expected %h got %h", name, exp, got);
        end
    endtask

    task automatic check_dword(input string name, input dword_t got, input dword_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s expected %h got %h", name, exp, got);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s expected %h got %h", name, exp, got);
        end
    endtask

    task automatic report_test(input string name);
        $display("%-14s checks %0d errors %0d", name, checks - test_checks, errors - test_errors);
        test_checks = checks;
        test_errors = errors;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic is_multi_cycle(input alu_op_e op);
        return is_mul_op(op) || is_div_op(op);
    endfunction

    function automatic word_t model_alu(input alu_op_e op, input word_t a, input word_t b,
                                        input dword_t hl, output logic ovf);
        longint sa;
        longint sb;
        longint wide;
        sa   = longint'($signed(a));
        sb   = longint'($signed(b));
        wide = (op == OP_SUB || op == OP_SUBU) ? sa - sb : sa + sb;
        // Signed result that does not survive truncation to 32 bits
        ovf  = (op == OP_ADD || op == OP_SUB) && (wide != longint'($signed(word_t'(wide))));
        case (op)
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU: return word_t'(wide);
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_NOR:  return ~(a | b);
            OP_SLT:  return word_t'(sa < sb);
            OP_SLTU: return word_t'(a < b);
            OP_MFHI: return hl[63:32];
            OP_MFLO: return hl[31:0];
            default: return '0;
        endcase
    endfunction

    function automatic dword_t model_product(input word_t a, input word_t b, input logic sgn);
        if (sgn)
            return dword_t'(longint'($signed(a)) * longint'($signed(b)));
        return {32'd0, a} * {32'd0, b};
    endfunction

    function automatic dword_t model_divide(input word_t a, input word_t b, input logic sgn);
        word_t q;
        word_t r;
        if (b == '0) begin
            q = '1; // Division by zero gives all ones and keeps the dividend
            r = a;
        end else if (sgn) begin
            q = word_t'(longint'($signed(a)) / longint'($signed(b)));
            r = word_t'(longint'($signed(a)) % longint'($signed(b)));
        end else begin
            q = a / b;
            r = a % b;
        end
        return {r, q};
    endfunction

    function automatic dword_t model_md(input alu_op_e op, input word_t a, input word_t b,
                                        input dword_t hl);
        case (op)
            OP_MULT:  return model_product(a, b, 1'b1);
            OP_MULTU: return model_product(a, b, 1'b0);
            OP_MADD:  return hl + model_product(a, b, 1'b1);
            OP_MADDU: return hl + model_product(a, b, 1'b0);
            OP_MSUB:  return hl - model_product(a, b, 1'b1);
            OP_MSUBU: return hl - model_product(a, b, 1'b0);
            OP_DIV:   return model_divide(a, b, 1'b1);
            default:  return model_divide(a, b, 1'b0);
        endcase
    endfunction

    function automatic word_t rand_word();
        case ($urandom_range(3))
            0: return word_t'($urandom_range(15));
            1: return 32'h7fff_fff0 + $urandom_range(15);
            2: return 32'h8000_0000 + $urandom_range(15);
            default: return $urandom;
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic drive(input alu_op_e o1, input word_t a1, input word_t b1,
                         input alu_op_e o2, input word_t a2, input word_t b2, input logic ex);
        op1          = o1;
        src1_a       = a1;
        src1_b       = b1;
        op2          = o2;
        src2_a       = a2;
        src2_b       = b2;
        flush_master = 1'b0;
        flush_slave  = 1'b0;
        flush_ex     = ex;
    endtask

    task automatic run_single(input alu_op_e o1, input word_t a1, input word_t b1,
                              input alu_op_e o2, input word_t a2, input word_t b2,
                              input logic ex);
        word_t exp1;
        word_t exp2;
        logic  ov1;
        logic  ov2;
        @(negedge clk_i);
        drive(o1, a1, b1, o2, a2, b2, ex);
        #SETTLE;
        exp1 = model_alu(o1, a1, b1, model_hilo, ov1);
        exp2 = model_alu(o2, a2, b2, model_hilo, ov2);
        check_word("result1_o", result1_o, exp1);
        check_word("result2_o", result2_o, exp2);
        check_bit("overflow1_o", overflow1_o, ov1);
        check_bit("overflow2_o", overflow2_o, ov2);
        check_bit("stall_o", stall_o, 1'b0);
        if (!ex) begin
            if (o2 == OP_MTHI) model_hilo[63:32] = a2;
            if (o2 == OP_MTLO) model_hilo[31:0] = a2;
            if (o1 == OP_MTHI) model_hilo[63:32] = a1; // Master applied last so it wins
            if (o1 == OP_MTLO) model_hilo[31:0] = a1;
        end
    endtask

    task automatic readback_hilo();
        @(negedge clk_i);
        drive(OP_MFHI, '0, '0, OP_MFLO, '0, '0, 1'b0);
        #SETTLE;
        check_dword("hilo", {result1_o, result2_o}, model_hilo);
    endtask

    task automatic run_multi(input alu_op_e o1, input word_t a1, input word_t b1,
                             input alu_op_e o2, input word_t a2, input word_t b2,
                             input logic ex);
        alu_op_e op;
        word_t   a;
        word_t   b;
        int      n;
        int      want;
        op   = is_multi_cycle(o1) ? o1 : o2;
        a    = is_multi_cycle(o1) ? a1 : a2;
        b    = is_multi_cycle(o1) ? b1 : b2;
        want = is_div_op(op) ? XLEN + 1 : XLEN / MUL_BITS;
        @(negedge clk_i);
        drive(o1, a1, b1, o2, a2, b2, ex);
        #SETTLE;
        n = 0;
        while (stall_o) begin
            n++;
            @(negedge clk_i);
            #SETTLE;
        end
        checks++;
        if (n != want) begin
            errors++;
            $display("Stall on %s lasted %0d cycles instead of %0d", op.name(), n, want);
        end
        if (!ex) begin
            model_hilo = model_md(op, a, b, model_hilo); // Written at the edge after ready
        end
    endtask

    task automatic run_flushed(input logic lane, input alu_op_e op, input word_t a,
                               input word_t b, input int wait_n);
        @(negedge clk_i);
        if (lane)
            drive(OP_NOP, '0, '0, op, a, b, 1'b0);
        else
            drive(op, a, b, OP_NOP, '0, '0, 1'b0);
        repeat (wait_n) @(negedge clk_i);
        if (lane)
            flush_slave = 1'b1;
        else
            flush_master = 1'b1;
        #SETTLE;
        check_bit("stall_o", stall_o, 1'b1);
        @(negedge clk_i);
        #SETTLE;
        check_bit("stall_o", stall_o, 1'b0);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        alu_op_e op;
        word_t   a;
        word_t   b;
        logic    lane;
        void'($urandom(32'h97ad));
        arst_n_i   = 1'b0;
        model_hilo = '0;
        drive(OP_NOP, '0, '0, OP_NOP, '0, '0, 1'b0);
        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;

        repeat (N_ALU) begin
            run_single(single_ops[$urandom_range(12)], rand_word(), rand_word(),
                       single_ops[$urandom_range(12)], rand_word(), rand_word(), 1'b0);
        end
        report_test("alu_random");

        repeat (N_MOVE) begin
            run_single(move_ops[$urandom_range(4)], $urandom, '0,
                       move_ops[$urandom_range(4)], $urandom, '0, $urandom_range(7) == 0);
        end
        readback_hilo();
        report_test("move_hilo");

        repeat (N_MD) begin
            op   = md_ops[$urandom_range(3)];
            a    = rand_word();
            b    = ($urandom_range(7) == 0) ? '0 : rand_word();
            lane = $urandom_range(1);
            if (lane)
                run_multi(OP_NOP, '0, '0, op, a, b, 1'b0);
            else
                run_multi(op, a, b, OP_NOP, '0, '0, 1'b0);
            readback_hilo();
        end
        report_test("muldiv_random");

        run_multi(OP_MULT, rand_word(), rand_word(), OP_NOP, '0, '0, 1'b0); // Seed HI/LO
        repeat (N_MAC) begin
            op   = mac_ops[$urandom_range(3)];
            lane = $urandom_range(1);
            if (lane)
                run_multi(OP_NOP, '0, '0, op, rand_word(), rand_word(), 1'b0);
            else
                run_multi(op, rand_word(), rand_word(), OP_NOP, '0, '0, 1'b0);
            readback_hilo();
        end
        report_test("mac_sequence");

        repeat (N_DUAL) begin
            run_multi(md_ops[$urandom_range(3)], rand_word(), rand_word(),
                      md_ops[$urandom_range(3)], rand_word(), rand_word(), 1'b0);
            readback_hilo();
        end
        report_test("dual_issue");

        for (int i = 0; i < N_FLUSH; i++) begin
            op   = md_ops[$urandom_range(3)];
            lane = $urandom_range(1);
            if (i % 2 == 0)
                run_flushed(lane, op, rand_word(), rand_word(), $urandom_range(1, 5));
            else if (lane)
                run_multi(OP_NOP, '0, '0, op, rand_word(), rand_word(), 1'b1);
            else
                run_multi(op, rand_word(), rand_word(), OP_NOP, '0, '0, 1'b1);
            readback_hilo();
        end
        report_test("flush");

        errors += i_ee_exec_top.i_muldiv_ctrl.i_ctrl_asserts.fail_count;
        $display("Total checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
